//--- project.f
+incdir+include
design/panel_pkg.sv
design/control_decode.sv
design/panel_settings.sv
design/frame_writer.sv
design/control_result.sv
design/control_top.sv
dv/control_model.sv
dv/control_tb.sv

//--- Makefile
# Verilator build and run of the LED panel controller testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module control_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vcontrol_tb)"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

//--- dv/control_tb.sv
//##########################################################################
// testbench of the LED panel command controller
// clock, reset, random command stream, checks against control_model
//##########################################################################

module control_tb;

    timeunit 1ns;
    timeprecision 1ps;

    `include "panel_params.svh"

    localparam int NUM_COMMANDS  = 200;
    localparam int READY_TIMEOUT = 200;
    localparam int BUSY_TIMEOUT  = 300;

    logic                   clk_in;
    logic                   reset;
    panel_pkg::byte_t       data_rx;
    logic                   data_ready_n;
    panel_pkg::rgb_enable_t rgb_enable;
    panel_pkg::brightness_t brightness;
    panel_pkg::fb_addr_t    ram_address;
    panel_pkg::pixel_t      ram_data_out;
    logic                   ram_write_enable;
    logic                   busy;
    logic                   ready_for_data;

    integer seed = 37;
    int     errors = 0;
    int     timeouts = 0;

    control_top i_dut (.*);

    control_model i_model (.*);

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_settings();
        check_equal("rgb_enable", 32'(i_model.exp_rgb), 32'(rgb_enable));
        check_equal("brightness", 32'(i_model.exp_brightness), 32'(brightness));
    endtask

    task automatic check_framebuffer(input int expected_writes);
        check_equal("write count", expected_writes, i_model.write_count);
        for (int i = 0; i < `PANEL_PIXELS; i++) begin
            check_equal($sformatf("pixel %0d", i), 32'(i_model.exp_fb[i]),
                        32'(i_model.obs_fb[i]));
        end
    endtask

    // one byte with the strobe low for one cycle once ready
    task automatic send_byte(input panel_pkg::byte_t value);
        int waited;
        waited = 0;
        @(negedge clk_in);
        while (!ready_for_data && waited < READY_TIMEOUT) begin
            @(negedge clk_in);
            waited++;
        end
        if (!ready_for_data) begin
            $display("timeout: ready_for_data stayed low for %0d cycles at %0t", waited, $time);
            timeouts++;
        end else begin
            @(posedge clk_in);
            data_rx      <= value;
            data_ready_n <= 1'b0;
            @(posedge clk_in);
            data_ready_n <= 1'b1;
        end
    endtask

    // a pixel write or sweep keeps the byte input closed until it is done
    task automatic wait_idle(input logic sweep);
        int waited;
        waited = 0;
        @(negedge clk_in);
        check_equal("busy", 1, 32'(busy));
        while (busy && waited < BUSY_TIMEOUT) begin
            if (sweep) begin
                check_equal("ready_for_data", 0, 32'(ready_for_data));
            end
            @(negedge clk_in);
            waited++;
        end
        if (busy) begin
            $display("timeout: busy still high after %0d cycles at %0t", waited, $time);
            timeouts++;
        end
    endtask

    // settings hold for one cycle and then take the new value
    task automatic run_single(input panel_pkg::byte_t op);
        i_model.clear_writes();
        send_byte(op);
        @(negedge clk_in);
        check_settings();
        i_model.apply_opcode(op);
        @(negedge clk_in);
        check_settings();
        check_equal("busy", 0, 32'(busy));
        check_equal("write count", 0, i_model.write_count);
    endtask

    task automatic run_sweep(input logic blank, input panel_pkg::pixel_t colour);
        i_model.clear_writes();
        if (blank) begin
            send_byte(panel_pkg::BLANKPANEL);
            i_model.fill_all('0);
        end else begin
            send_byte(panel_pkg::FILLPANEL);
            send_byte(colour);
            i_model.fill_all(colour);
        end
        wait_idle(1'b1);
        check_framebuffer(`PANEL_PIXELS);
        for (int i = 0; i < `PANEL_PIXELS; i++) begin
            check_equal("ram_address", i, 32'(i_model.addr_log[i]));
        end
    endtask

    task automatic run_pixel(input panel_pkg::byte_t addr, input panel_pkg::pixel_t colour);
        i_model.clear_writes();
        send_byte(panel_pkg::READPIXEL);
        send_byte(addr);
        send_byte(colour);
        i_model.write_pixel(addr, colour);
        wait_idle(1'b1);
        check_framebuffer(1);
        check_equal("ram_address", 32'(addr[5:0]), 32'(i_model.addr_log[0]));
    endtask

    task automatic run_brightness_load(input panel_pkg::byte_t arg);
        i_model.clear_writes();
        send_byte(panel_pkg::READBRIGHTNESS);
        send_byte(arg);
        i_model.load_brightness(arg);
        wait_idle(1'b0);
        check_settings();
        check_equal("write count", 0, i_model.write_count);
    endtask

    // no new byte may be taken while a write is on the port
    always @(negedge clk_in) begin
        if (!reset && ram_write_enable) begin
            check_equal("ready_for_data", 0, 32'(ready_for_data));
        end
    end

    initial begin
        logic [7:0]       pick;
        panel_pkg::byte_t arg_a;
        panel_pkg::byte_t arg_b;
        reset        = 1'b1;
        data_rx      = '0;
        data_ready_n = 1'b1;
        repeat (4) @(posedge clk_in);
        reset <= 1'b0;
        @(negedge clk_in);
        check_settings();
        check_equal("busy", 0, 32'(busy));
        check_equal("ready_for_data", 1, 32'(ready_for_data));

        for (int n = 0; n < NUM_COMMANDS; n++) begin
            pick  = 8'($unsigned($random(seed)) % 10);
            arg_a = 8'($random(seed));
            arg_b = 8'($random(seed));
            case (pick)
                8'd0, 8'd1: run_single(8'h01 + arg_a % 8'd6);
                8'd2, 8'd3: run_single(8'h11 + arg_a % 8'd6);
                8'd4: run_single(arg_a[0] ? 8'h19 : 8'h10);
                8'd5: run_brightness_load(arg_b);
                8'd6: run_sweep(1'b1, '0);
                8'd7: run_sweep(1'b0, arg_b);
                8'd8: run_pixel(arg_a, arg_b);
                // 0x40 and up is never an opcode
                default: run_single(8'h40 + arg_a % 8'hc0);
            endcase
        end

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- dv/control_model.sv
//##########################################################################
// reference model of the panel controller
// expected settings and framebuffer, observed framebuffer and write log
//##########################################################################

module control_model (
    input logic                clk_in,
    input logic                ram_write_enable,
    input panel_pkg::fb_addr_t ram_address,
    input panel_pkg::pixel_t   ram_data_out
);

    timeunit 1ns;
    timeprecision 1ps;

    `include "panel_params.svh"

    panel_pkg::rgb_enable_t exp_rgb;
    panel_pkg::brightness_t exp_brightness;
    panel_pkg::pixel_t      exp_fb [`PANEL_PIXELS];
    panel_pkg::pixel_t      obs_fb [`PANEL_PIXELS];
    panel_pkg::fb_addr_t    addr_log [`PANEL_PIXELS];
    int                     write_count;

    // both copies start from the same address pattern
    initial begin
        exp_rgb        = '1;
        exp_brightness = '1;
        write_count    = 0;
        for (int i = 0; i < `PANEL_PIXELS; i++) begin
            exp_fb[i] = 8'(i * 37 + 11);
            obs_fb[i] = exp_fb[i];
        end
    end

    // single byte opcodes, anything else is ignored
    task automatic apply_opcode(input panel_pkg::byte_t op);
        case (op)
            8'h01: exp_rgb[0] = 1'b1;
            8'h02: exp_rgb[0] = 1'b0;
            8'h03: exp_rgb[1] = 1'b1;
            8'h04: exp_rgb[1] = 1'b0;
            8'h05: exp_rgb[2] = 1'b1;
            8'h06: exp_rgb[2] = 1'b0;
            8'h10: exp_brightness = '0;
            // step k toggles bit 6 - k
            8'h11: exp_brightness[5] = ~exp_brightness[5];
            8'h12: exp_brightness[4] = ~exp_brightness[4];
            8'h13: exp_brightness[3] = ~exp_brightness[3];
            8'h14: exp_brightness[2] = ~exp_brightness[2];
            8'h15: exp_brightness[1] = ~exp_brightness[1];
            8'h16: exp_brightness[0] = ~exp_brightness[0];
            8'h19: exp_brightness = '1;
            default: ;
        endcase
    endtask

    task automatic load_brightness(input panel_pkg::byte_t arg);
        exp_brightness = arg[5:0];
    endtask

    task automatic fill_all(input panel_pkg::pixel_t colour);
        for (int i = 0; i < `PANEL_PIXELS; i++) begin
            exp_fb[i] = colour;
        end
    endtask

    task automatic write_pixel(input panel_pkg::byte_t addr, input panel_pkg::pixel_t colour);
        exp_fb[addr[5:0]] = colour;
    endtask

    task automatic clear_writes();
        write_count = 0;
    endtask

    // write port is stable between edges
    always @(negedge clk_in) begin
        if (ram_write_enable) begin
            obs_fb[ram_address] = ram_data_out;
            if (write_count < `PANEL_PIXELS) begin
                addr_log[write_count] = ram_address;
            end
            write_count++;
        end
    end

endmodule

//--- design/control_top.sv
//##########################################################################
// LED panel command controller, top level
// decode, settings and frame writer, result stage
//##########################################################################

module control_top (
    input  logic                   clk_in,
    input  logic                   reset,
    input  panel_pkg::byte_t       data_rx,
    input  logic                   data_ready_n,
    output panel_pkg::rgb_enable_t rgb_enable,
    output panel_pkg::brightness_t brightness,
    output panel_pkg::fb_addr_t    ram_address,
    output panel_pkg::pixel_t      ram_data_out,
    output logic                   ram_write_enable,
    output logic                   busy,
    output logic                   ready_for_data
);

    panel_pkg::settings_op_t settings_op;
    panel_pkg::pixel_req_t   pixel_req;
    panel_pkg::ram_write_t   ram_write;
    logic                    cmd_pending;
    logic                    settings_applied;
    logic                    sweep_active;

    control_decode i_decode (
        .clk_in        (clk_in),
        .reset         (reset),
        .data_rx       (data_rx),
        .data_ready_n  (data_ready_n),
        .ready_for_data(ready_for_data),
        .settings_op   (settings_op),
        .pixel_req     (pixel_req),
        .cmd_pending   (cmd_pending)
    );

    panel_settings i_settings (
        .clk_in          (clk_in),
        .reset           (reset),
        .settings_op     (settings_op),
        .rgb_enable      (rgb_enable),
        .brightness      (brightness),
        .settings_applied(settings_applied)
    );

    frame_writer i_writer (
        .clk_in      (clk_in),
        .reset       (reset),
        .pixel_req   (pixel_req),
        .ram_write   (ram_write),
        .sweep_active(sweep_active)
    );

    // ready_for_data loops back to decode from here
    control_result i_result (
        .clk_in          (clk_in),
        .reset           (reset),
        .ram_write       (ram_write),
        .sweep_active    (sweep_active),
        .cmd_pending     (cmd_pending),
        .settings_applied(settings_applied),
        .ram_address     (ram_address),
        .ram_data_out    (ram_data_out),
        .ram_write_enable(ram_write_enable),
        .busy            (busy),
        .ready_for_data  (ready_for_data)
    );

endmodule

//--- design/control_result.sv
//##########################################################################
// result stage
// registered write port, busy level and ready_for_data
//##########################################################################

module control_result (
    input  logic                  clk_in,
    input  logic                  reset,
    input  panel_pkg::ram_write_t ram_write,
    input  logic                  sweep_active,
    input  logic                  cmd_pending,
    input  logic                  settings_applied,
    output panel_pkg::fb_addr_t   ram_address,
    output panel_pkg::pixel_t     ram_data_out,
    output logic                  ram_write_enable,
    output logic                  busy,
    output logic                  ready_for_data
);

    logic last_write_out;

    // writes are back to back, so a write with the sweep already gone is the last
    assign last_write_out = ram_write_enable && !sweep_active;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            ram_write_enable <= 1'b0;
            busy             <= 1'b0;
        end else begin
            ram_write_enable <= ram_write.write_enable;
            // new work wins over the end of the old one
            busy <= cmd_pending || (busy && !(last_write_out || settings_applied));
        end
    end

    always_ff @(posedge clk_in) begin
        ram_address  <= ram_write.addr;
        ram_data_out <= ram_write.data;
    end

    assign ready_for_data = !sweep_active && !ram_write_enable;

    a_quiet_after_reset: assert property (@(posedge clk_in)
        $past(reset) |-> !ram_write_enable);

endmodule

//--- design/frame_writer.sv
//##########################################################################
// framebuffer write generator
// blank and fill sweeps over all pixels, single pixel writes
//##########################################################################

module frame_writer (
    input  logic                  clk_in,
    input  logic                  reset,
    input  panel_pkg::pixel_req_t pixel_req,
    output panel_pkg::ram_write_t ram_write,
    output logic                  sweep_active
);

    `include "panel_params.svh"

    panel_pkg::pixel_op_kind_t kind_q;
    panel_pkg::fb_addr_t       addr_q;
    panel_pkg::pixel_t         colour_q;
    logic                      start;
    logic                      active;
    logic                      last;

    assign start  = pixel_req.kind != panel_pkg::NONE;
    assign active = kind_q != panel_pkg::NONE;

    // a pixel write is one cycle, a sweep ends on the top address
    assign last = (kind_q == panel_pkg::PIXEL)
               || (addr_q == panel_pkg::fb_addr_t'(`PANEL_PIXELS - 1));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            kind_q <= panel_pkg::NONE;
        end else if (start) begin
            kind_q <= pixel_req.kind;
        end else if (active && last) begin
            kind_q <= panel_pkg::NONE;
        end
    end

    always_ff @(posedge clk_in) begin
        if (start) begin
            if (pixel_req.kind == panel_pkg::PIXEL) begin
                addr_q <= pixel_req.addr;
            end else begin
                addr_q <= '0;
            end
            if (pixel_req.kind == panel_pkg::BLANK) begin
                colour_q <= '0;
            end else begin
                colour_q <= pixel_req.colour;
            end
        end else if (active && !last) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    assign ram_write = '{write_enable: active, addr: addr_q, data: colour_q};

    // also covers the request cycle so no byte slips in before the sweep
    assign sweep_active = active || start;

    a_no_idle_write: assert property (@(posedge clk_in) disable iff (reset)
        ram_write.write_enable |-> $past(sweep_active));

    // decode and result must hold off new requests until the sweep is done
    a_no_overlap: assert property (@(posedge clk_in) disable iff (reset)
        start |-> !active);

endmodule

//--- design/panel_settings.sv
//##########################################################################
// panel settings registers
// colour channel enables and brightness mask
//##########################################################################

module panel_settings (
    input  logic                    clk_in,
    input  logic                    reset,
    input  panel_pkg::settings_op_t settings_op,
    output panel_pkg::rgb_enable_t  rgb_enable,
    output panel_pkg::brightness_t  brightness,
    output logic                    settings_applied
);

    `include "panel_params.svh"

    logic [2:0]             step_k;
    panel_pkg::brightness_t step_mask;

    // step opcodes 0x11..0x16 carry k in their low bits
    assign step_k    = settings_op.opcode[2:0];
    assign step_mask = panel_pkg::brightness_t'(1) << (`PANEL_BRIGHTNESS_LEVELS - step_k);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_enable       <= '1;
            brightness       <= '1;
            settings_applied <= 1'b0;
        end else begin
            settings_applied <= 1'b0;
            if (settings_op.valid) begin
                case (settings_op.opcode)
                    panel_pkg::RED_ENABLE: rgb_enable[0] <= 1'b1;
                    panel_pkg::RED_DISABLE: rgb_enable[0] <= 1'b0;
                    panel_pkg::GREEN_ENABLE: rgb_enable[1] <= 1'b1;
                    panel_pkg::GREEN_DISABLE: rgb_enable[1] <= 1'b0;
                    panel_pkg::BLUE_ENABLE: rgb_enable[2] <= 1'b1;
                    panel_pkg::BLUE_DISABLE: rgb_enable[2] <= 1'b0;
                    panel_pkg::BRIGHTNESS_ZERO: brightness <= '0;
                    panel_pkg::BRIGHTNESS_ONE,
                    panel_pkg::BRIGHTNESS_TWO,
                    panel_pkg::BRIGHTNESS_THREE,
                    panel_pkg::BRIGHTNESS_FOUR,
                    panel_pkg::BRIGHTNESS_FIVE,
                    panel_pkg::BRIGHTNESS_SIX: brightness <= brightness ^ step_mask;
                    panel_pkg::BRIGHTNESS_NINE: brightness <= '1;
                    panel_pkg::READBRIGHTNESS: begin
                        // low bits of the argument byte
                        brightness       <= panel_pkg::brightness_t'(settings_op.arg);
                        settings_applied <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- design/control_decode.sv
//##########################################################################
// command byte decoder
// opcode FSM, argument collection, settings ops and pixel requests
//##########################################################################

module control_decode (
    input  logic                    clk_in,
    input  logic                    reset,
    input  panel_pkg::byte_t        data_rx,
    input  logic                    data_ready_n,
    input  logic                    ready_for_data,
    output panel_pkg::settings_op_t settings_op,
    output panel_pkg::pixel_req_t   pixel_req,
    output logic                    cmd_pending
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_BRIGHTNESS,
        WAIT_FILL_COLOUR,
        WAIT_PIXEL_ADDR,
        WAIT_PIXEL_COLOUR
    } decode_state_t;

    decode_state_t             state;
    panel_pkg::opcode_t        opcode;
    logic                      accept;
    logic                      multi_byte;
    logic                      settings_opcode;

    // registered outputs
    logic                      op_valid;
    panel_pkg::opcode_t        op_opcode;
    panel_pkg::byte_t          op_arg;
    panel_pkg::pixel_op_kind_t req_kind;
    panel_pkg::fb_addr_t       req_addr;
    panel_pkg::pixel_t         req_colour;

    // address byte of READPIXEL, held until its colour arrives
    panel_pkg::fb_addr_t       pixel_addr;

    assign accept = !data_ready_n && ready_for_data;
    assign opcode = panel_pkg::opcode_t'(data_rx);

    assign multi_byte = opcode inside {panel_pkg::READBRIGHTNESS, panel_pkg::BLANKPANEL,
                                       panel_pkg::FILLPANEL, panel_pkg::READPIXEL};
    assign settings_opcode = opcode inside {
        [panel_pkg::RED_ENABLE : panel_pkg::BLUE_DISABLE],
        [panel_pkg::BRIGHTNESS_ZERO : panel_pkg::BRIGHTNESS_SIX],
        panel_pkg::BRIGHTNESS_NINE
    };

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state    <= IDLE;
            op_valid <= 1'b0;
            req_kind <= panel_pkg::NONE;
        end else begin
            op_valid <= 1'b0;
            req_kind <= panel_pkg::NONE;
            if (accept) begin
                case (state)
                    IDLE: begin
                        op_valid <= settings_opcode;
                        case (opcode)
                            panel_pkg::READBRIGHTNESS: state <= WAIT_BRIGHTNESS;
                            panel_pkg::BLANKPANEL: req_kind <= panel_pkg::BLANK;
                            panel_pkg::FILLPANEL: state <= WAIT_FILL_COLOUR;
                            panel_pkg::READPIXEL: state <= WAIT_PIXEL_ADDR;
                            // unknown bytes fall through, nothing happens
                            default: ;
                        endcase
                    end
                    WAIT_BRIGHTNESS: begin
                        op_valid <= 1'b1;
                        state    <= IDLE;
                    end
                    WAIT_FILL_COLOUR: begin
                        req_kind <= panel_pkg::FILL;
                        state    <= IDLE;
                    end
                    WAIT_PIXEL_ADDR: state <= WAIT_PIXEL_COLOUR;
                    WAIT_PIXEL_COLOUR: begin
                        req_kind <= panel_pkg::PIXEL;
                        state    <= IDLE;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // payload, only meaningful alongside op_valid or req_kind
    always_ff @(posedge clk_in) begin
        if (accept) begin
            op_opcode  <= (state == IDLE) ? opcode : panel_pkg::READBRIGHTNESS;
            op_arg     <= data_rx;
            req_addr   <= pixel_addr;
            req_colour <= data_rx;
            if (state == WAIT_PIXEL_ADDR) begin
                pixel_addr <= panel_pkg::fb_addr_t'(data_rx);
            end
        end
    end

    assign settings_op = '{valid: op_valid, opcode: op_opcode, arg: op_arg};
    assign pixel_req   = '{kind: req_kind, addr: req_addr, colour: req_colour};

    // long command in flight somewhere between here and the execute stage
    assign cmd_pending = (state == IDLE && accept && multi_byte)
                      || (state != IDLE)
                      || (req_kind != panel_pkg::NONE)
                      || (op_valid && op_opcode == panel_pkg::READBRIGHTNESS);

    a_one_target: assert property (@(posedge clk_in) disable iff (reset)
        !(settings_op.valid && pixel_req.kind != panel_pkg::NONE));

endmodule

//--- design/panel_pkg.sv
//##########################################################################
// shared types of the panel controller
// opcodes, vector typedefs and the structs passed between stages
//##########################################################################

package panel_pkg;

    `include "panel_params.svh"

    typedef logic [7:0] byte_t;
    typedef logic [`PANEL_FB_ADDR_BITS-1:0] fb_addr_t;
    typedef logic [`PANEL_PIXEL_BITS-1:0] pixel_t;
    typedef logic [`PANEL_BRIGHTNESS_LEVELS-1:0] brightness_t;

    // bit 0 red, bit 1 green, bit 2 blue
    typedef logic [2:0] rgb_enable_t;

    typedef enum logic [7:0] {
        RED_ENABLE       = 8'h01,
        RED_DISABLE      = 8'h02,
        GREEN_ENABLE     = 8'h03,
        GREEN_DISABLE    = 8'h04,
        BLUE_ENABLE      = 8'h05,
        BLUE_DISABLE     = 8'h06,
        BRIGHTNESS_ZERO  = 8'h10,
        BRIGHTNESS_ONE   = 8'h11,
        BRIGHTNESS_TWO   = 8'h12,
        BRIGHTNESS_THREE = 8'h13,
        BRIGHTNESS_FOUR  = 8'h14,
        BRIGHTNESS_FIVE  = 8'h15,
        BRIGHTNESS_SIX   = 8'h16,
        BRIGHTNESS_NINE  = 8'h19,
        READBRIGHTNESS   = 8'h20,
        BLANKPANEL       = 8'h21,
        FILLPANEL        = 8'h22,
        READPIXEL        = 8'h23
    } opcode_t;

    // decode to panel_settings
    typedef struct packed {
        logic    valid;
        opcode_t opcode;
        byte_t   arg;
    } settings_op_t;

    typedef enum logic [1:0] {
        NONE,
        BLANK,
        FILL,
        PIXEL
    } pixel_op_kind_t;

    // decode to frame_writer, any kind but NONE starts it
    typedef struct packed {
        pixel_op_kind_t kind;
        fb_addr_t       addr;
        pixel_t         colour;
    } pixel_req_t;

    // framebuffer write port
    typedef struct packed {
        logic     write_enable;
        fb_addr_t addr;
        pixel_t   data;
    } ram_write_t;

endpackage

//--- include/panel_params.svh
//##########################################################################
// size macros for the LED panel command controller
// framebuffer geometry, pixel width and brightness mask width
//##########################################################################

`ifndef PANEL_PARAMS_SVH
`define PANEL_PARAMS_SVH

// pixel address width, one flat address per pixel
`define PANEL_FB_ADDR_BITS 6

// pixels in the framebuffer
`define PANEL_PIXELS 64

// one pixel value
`define PANEL_PIXEL_BITS 8

// bits in the brightness mask
`define PANEL_BRIGHTNESS_LEVELS 6

`endif
